// File: project.f
+incdir+tb
source/ternary_pkg.sv
source/trit_logic_unit.sv
source/trit_ripple_adder.sv
source/trit_comparator.sv
source/alu_result_stage.sv
source/ternary_alu.sv
tb/tb_ternary_alu.sv

// File: tb/alu_reference.svh
// Integer reference model for the balanced-ternary ALU
// Converts words to and from signed integers and computes the
// expected response of every operation. ADD and SUB wrap into the
// balanced range of one word; the logic operations go trit by trit.
`ifndef ALU_REFERENCE_SVH
`define ALU_REFERENCE_SVH

localparam int FULL_RANGE = 3 ** ternary_pkg::WORD_TRITS;
localparam int HALF_RANGE = (FULL_RANGE - 1) / 2;

function automatic int trit_value(input ternary_pkg::trit_t t);
    case (t)
        ternary_pkg::TRIT_NEG: return -1;
        ternary_pkg::TRIT_POS: return 1;
        default:               return 0;
    endcase
endfunction

function automatic ternary_pkg::trit_t value_to_trit(input int v);
    if (v > 0) return ternary_pkg::TRIT_POS;
    if (v < 0) return ternary_pkg::TRIT_NEG;
    return ternary_pkg::TRIT_ZERO;
endfunction

function automatic int word_to_int(input ternary_pkg::word_t w);
    int value;
    value = 0;
    for (int i = ternary_pkg::WORD_TRITS - 1; i >= 0; i--) begin
        value = value * 3 + trit_value(w[2*i +: 2]);
    end
    return value;
endfunction

// Fold any integer back into -HALF_RANGE..+HALF_RANGE
function automatic int wrap_range(input int v);
    int m;
    m = (v + HALF_RANGE) % FULL_RANGE;
    if (m < 0) m += FULL_RANGE;
    return m - HALF_RANGE;
endfunction

function automatic ternary_pkg::word_t int_to_word(input int v);
    ternary_pkg::word_t w;
    int rest;
    int digit;
    rest = wrap_range(v);
    for (int i = 0; i < ternary_pkg::WORD_TRITS; i++) begin
        // Remainder truncates toward zero, so it lies in -2..2
        digit = rest % 3;
        if (digit > 1) digit -= 3;
        if (digit < -1) digit += 3;
        w[2*i +: 2] = value_to_trit(digit);
        rest = (rest - digit) / 3;
    end
    return w;
endfunction

function automatic ternary_pkg::alu_resp_t ref_alu(input ternary_pkg::alu_req_t r);
    ternary_pkg::alu_resp_t e;
    int x;
    int y;
    x = word_to_int(r.a);
    y = word_to_int(r.b);
    e.op = r.op;
    for (int i = 0; i < ternary_pkg::WORD_TRITS; i++) begin
        case (r.op)
            ternary_pkg::OP_NOT: e.result[2*i +: 2] = ternary_pkg::trit_neg(r.a[2*i +: 2]);
            ternary_pkg::OP_AND: e.result[2*i +: 2] = ternary_pkg::trit_min(r.a[2*i +: 2],
                                                                           r.b[2*i +: 2]);
            ternary_pkg::OP_OR:  e.result[2*i +: 2] = ternary_pkg::trit_max(r.a[2*i +: 2],
                                                                           r.b[2*i +: 2]);
            ternary_pkg::OP_XOR: e.result[2*i +: 2] = ternary_pkg::trit_xor(r.a[2*i +: 2],
                                                                           r.b[2*i +: 2]);
            default:             e.result[2*i +: 2] = ternary_pkg::TRIT_ZERO;
        endcase
    end
    case (r.op)
        ternary_pkg::OP_ADD:  e.result = int_to_word(x + y);
        ternary_pkg::OP_SUB:  e.result = int_to_word(x - y);
        ternary_pkg::OP_COMP: e.result = int_to_word((x < y) ? -1 : (x == y) ? 0 : 1);
        ternary_pkg::OP_NOT, ternary_pkg::OP_AND, ternary_pkg::OP_OR, ternary_pkg::OP_XOR: ;
        default:              e.result = r.a;
    endcase
    return e;
endfunction

`endif

// File: tb/tb_ternary_alu.sv
// Testbench for the balanced-ternary ALU
// Runs directed and random requests through the valid/ready
// interface, checks every response against the integer model,
// and checks latency, ordering and stall behavior.
`timescale 1ns/1ns

module tb_ternary_alu;

    `include "alu_reference.svh"

    localparam int CLOCK_PERIOD   = 100;
    localparam int NUM_RANDOM     = 100;
    localparam int DIRECTED_TESTS = 15;
    localparam int TOTAL_TESTS    = DIRECTED_TESTS + 4 * NUM_RANDOM;

    integer seed = 32'h6a34_03c7;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   req_valid;
    logic                   req_ready;
    ternary_pkg::alu_req_t  req;
    logic                   resp_valid;
    logic                   resp_ready;
    ternary_pkg::alu_resp_t resp;

    // Expected responses in request order with their labels and accept cycles
    ternary_pkg::alu_resp_t expected_q[$];
    string                  name_q[$];
    int                     accept_q[$];

    int   cycle = 0;
    logic throttle = 1'b0;
    logic timed = 1'b1;

    ternary_alu u_ternary_alu (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    // Random back-pressure stalls about one cycle in three
    always @(posedge clock) begin
        if (throttle) resp_ready <= ({$random(seed)} % 3) != 0;
        else resp_ready <= 1'b1;
    end

    task automatic check_resp(input string name, input ternary_pkg::alu_resp_t expected,
                              input ternary_pkg::alu_resp_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected op %0d result %h actual op %0d result %h",
                     name, expected.op, expected.result, actual.op, actual.result);
            $display("Test failed");
            $fatal(1, "Response mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Control signal mismatch");
        end
    endtask

    function automatic ternary_pkg::word_t random_word();
        ternary_pkg::word_t w;
        int draw;
        for (int i = 0; i < ternary_pkg::WORD_TRITS; i++) begin
            draw = {$random(seed)} % 3;
            w[2*i +: 2] = value_to_trit(draw - 1);
        end
        return w;
    endfunction

    // Holds the request until it is accepted, then logs what to expect
    task automatic send(input string name, input ternary_pkg::alu_op_e op,
                        input ternary_pkg::word_t a, input ternary_pkg::word_t b);
        ternary_pkg::alu_req_t r;
        r.op = op;
        r.a  = a;
        r.b  = b;
        req       <= r;
        req_valid <= 1'b1;
        @(posedge clock);
        while (!req_ready) @(posedge clock);
        expected_q.push_back(ref_alu(r));
        name_q.push_back(name);
        accept_q.push_back(timed ? cycle : -1);
    endtask

    task automatic drain();
        req_valid <= 1'b0;
        while (expected_q.size() != 0) @(posedge clock);
        repeat (2) @(posedge clock);
    endtask

    always @(posedge clock) begin : compare_responses
        ternary_pkg::alu_resp_t expected;
        ternary_pkg::alu_resp_t held_resp;
        string                  name;
        int                     accepted;
        logic                   stalled;
        if (reset) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                check_flag("stalled resp_valid", 1'b1, resp_valid);
                check_resp("stalled resp hold", held_resp, resp);
            end
            // Ready when the register is empty or its response leaves now
            if (resp_valid && !resp_ready) begin
                check_flag("req_ready under stall", 1'b0, req_ready);
            end else begin
                check_flag("req_ready with free slot", 1'b1, req_ready);
            end
            if (resp_valid && resp_ready) begin
                if (expected_q.size() == 0) begin
                    $display("A response arrived with no request outstanding");
                    $display("Test failed");
                    $fatal(1, "Unexpected response");
                end
                expected = expected_q.pop_front();
                name     = name_q.pop_front();
                accepted = accept_q.pop_front();
                check_resp(name, expected, resp);
                if (accepted >= 0) begin
                    check_flag({name, " latency"}, 1'b1, cycle == accepted + 1);
                end
            end
            stalled   = resp_valid && !resp_ready;
            held_resp = resp;
        end
    end

    initial begin : watchdog
        #(longint'(TOTAL_TESTS * 4 + 200) * CLOCK_PERIOD);
        $display("Run timed out before all responses were received");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

    initial begin : stimulus
        ternary_pkg::word_t pair_a;
        ternary_pkg::word_t pair_b;
        ternary_pkg::word_t a;
        ternary_pkg::word_t b;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_flag("reset resp_valid", 1'b0, resp_valid);
        check_flag("reset req_ready", 1'b1, req_ready);

        // Trit i of the two words covers all nine pairs
        for (int i = 0; i < ternary_pkg::WORD_TRITS; i++) begin
            pair_a[2*i +: 2] = value_to_trit(i / 3 - 1);
            pair_b[2*i +: 2] = value_to_trit(i % 3 - 1);
        end
        send("not pairs", ternary_pkg::OP_NOT, pair_a, pair_b);
        send("and pairs", ternary_pkg::OP_AND, pair_a, pair_b);
        send("or pairs", ternary_pkg::OP_OR, pair_a, pair_b);
        send("xor pairs", ternary_pkg::OP_XOR, pair_a, pair_b);
        send("pass-through", ternary_pkg::alu_op_e'(3'd7), pair_a, pair_b);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send("random logic", ternary_pkg::alu_op_e'({$random(seed)} % 4),
                 random_word(), random_word());
        end

        send("add carry chain", ternary_pkg::OP_ADD, int_to_word(3280), int_to_word(1));
        send("add overflow", ternary_pkg::OP_ADD, int_to_word(HALF_RANGE), int_to_word(1));
        send("sub underflow", ternary_pkg::OP_SUB, int_to_word(-HALF_RANGE), int_to_word(1));
        send("add min twice", ternary_pkg::OP_ADD, int_to_word(-HALF_RANGE),
             int_to_word(-HALF_RANGE));
        a = random_word();
        send("add a plus neg a", ternary_pkg::OP_ADD, a, int_to_word(-word_to_int(a)));
        send("sub a minus a", ternary_pkg::OP_SUB, a, a);
        send("sub zero minus max", ternary_pkg::OP_SUB, '0, int_to_word(HALF_RANGE));
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send("random arith", ({$random(seed)} % 2) ? ternary_pkg::OP_ADD :
                 ternary_pkg::OP_SUB, random_word(), random_word());
        end

        b = random_word();
        send("comp equal", ternary_pkg::OP_COMP, b, b);
        send("comp top greater", ternary_pkg::OP_COMP, int_to_word(6561), '0);
        send("comp top less", ternary_pkg::OP_COMP, '0, int_to_word(6561));
        for (int n = 0; n < NUM_RANDOM; n++) begin
            a = random_word();
            b = (n % 4 == 0) ? a : random_word();
            send("random comp", ternary_pkg::OP_COMP, a, b);
        end
        drain();

        // Back-to-back traffic under random stalls without the latency check
        timed    = 1'b0;
        throttle <= 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send("stalled random", ternary_pkg::alu_op_e'({$random(seed)} % 8),
                 random_word(), random_word());
        end
        drain();
        throttle <= 1'b0;
        repeat (2) @(posedge clock);

        if (expected_q.size() == 0 && !resp_valid) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Responses were left outstanding at the end of the run");
            $display("Test failed");
            $fatal(1, "Outstanding responses");
        end
    end

endmodule

// File: source/ternary_alu.sv
// Balanced-ternary ALU top level
// Fans the request operands out to the logic unit, the adder and
// the comparator, which all settle in the same cycle, and hands
// their words to the result stage. One cycle from accepted request
// to response, with a valid/ready handshake on both sides.
`timescale 1ns/1ns

module ternary_alu (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  ternary_pkg::alu_req_t  req,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output ternary_pkg::alu_resp_t resp
);

    ternary_pkg::word_t not_word;
    ternary_pkg::word_t and_word;
    ternary_pkg::word_t or_word;
    ternary_pkg::word_t xor_word;
    ternary_pkg::word_t sum_word;
    ternary_pkg::word_t diff_word;
    ternary_pkg::word_t comp_word;

    trit_logic_unit u_logic (
        .a        (req.a),
        .b        (req.b),
        .not_word (not_word),
        .and_word (and_word),
        .or_word  (or_word),
        .xor_word (xor_word)
    );

    trit_ripple_adder u_adder (
        .a         (req.a),
        .b         (req.b),
        .sum_word  (sum_word),
        .diff_word (diff_word)
    );

    trit_comparator u_comparator (
        .a         (req.a),
        .b         (req.b),
        .comp_word (comp_word)
    );

    alu_result_stage u_result (
        .clock      (clock),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .not_word   (not_word),
        .and_word   (and_word),
        .or_word    (or_word),
        .xor_word   (xor_word),
        .sum_word   (sum_word),
        .diff_word  (diff_word),
        .comp_word  (comp_word),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

endmodule

// File: source/alu_result_stage.sv
// ALU result select and output register
// Picks the unit output named by the request operation, or operand a
// for the spare code, and holds it in a one-entry valid/ready stage.
// A request is taken whenever the register is empty or draining.
`timescale 1ns/1ns

module alu_result_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  ternary_pkg::alu_req_t  req,
    input  ternary_pkg::word_t     not_word,
    input  ternary_pkg::word_t     and_word,
    input  ternary_pkg::word_t     or_word,
    input  ternary_pkg::word_t     xor_word,
    input  ternary_pkg::word_t     sum_word,
    input  ternary_pkg::word_t     diff_word,
    input  ternary_pkg::word_t     comp_word,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output ternary_pkg::alu_resp_t resp
);

    ternary_pkg::word_t selected;
    logic               accept;

    // Result mux
    always_comb begin
        case (req.op)
            ternary_pkg::OP_NOT:  selected = not_word;
            ternary_pkg::OP_AND:  selected = and_word;
            ternary_pkg::OP_OR:   selected = or_word;
            ternary_pkg::OP_XOR:  selected = xor_word;
            ternary_pkg::OP_ADD:  selected = sum_word;
            ternary_pkg::OP_SUB:  selected = diff_word;
            ternary_pkg::OP_COMP: selected = comp_word;
            default:              selected = req.a;
        endcase
    end

    // Free slot, or the held response leaves this cycle
    assign req_ready = !resp_valid || resp_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // Payload only moves on accept and holds under back-pressure
    always_ff @(posedge clock) begin
        if (accept) begin
            resp.op     <= req.op;
            resp.result <= selected;
        end
    end

endmodule

// File: source/trit_comparator.sv
// Three-way ternary word compare
// Walks from the most significant trit down, carrying less-than and
// equal flags. Trit 0 of the result is -1, 0 or +1 for a < b, a = b
// and a > b; every other trit is 0.
`timescale 1ns/1ns

module trit_comparator (
    input  ternary_pkg::word_t a,
    input  ternary_pkg::word_t b,
    output ternary_pkg::word_t comp_word
);

    localparam int N = ternary_pkg::WORD_TRITS;

    // Order is -1 < 0 < +1
    function automatic logic trit_less(
        input ternary_pkg::trit_t x,
        input ternary_pkg::trit_t y
    );
        ternary_pkg::trit_t p;
        ternary_pkg::trit_t q;
        p = ternary_pkg::trit_norm(x);
        q = ternary_pkg::trit_norm(y);
        return (p == ternary_pkg::TRIT_NEG && q != ternary_pkg::TRIT_NEG) ||
               (p == ternary_pkg::TRIT_ZERO && q == ternary_pkg::TRIT_POS);
    endfunction

    // Index N is the seed above the top trit
    logic [N:0]          lt_chain;
    logic [N:0]          eq_chain;
    ternary_pkg::trit_t  outcome;

    assign lt_chain[N] = 1'b0;
    assign eq_chain[N] = 1'b1;

    for (genvar i = N - 1; i >= 0; i--) begin : g_trit
        assign lt_chain[i] = lt_chain[i+1] |
                             (eq_chain[i+1] & trit_less(a[2*i +: 2], b[2*i +: 2]));
        assign eq_chain[i] = eq_chain[i+1] &
                             (ternary_pkg::trit_norm(a[2*i +: 2]) ==
                              ternary_pkg::trit_norm(b[2*i +: 2]));
    end

    assign outcome = lt_chain[0] ? ternary_pkg::TRIT_NEG  :
                     eq_chain[0] ? ternary_pkg::TRIT_ZERO :
                                   ternary_pkg::TRIT_POS;

    assign comp_word = {{(2*N-2){1'b0}}, outcome};

endmodule

// File: source/trit_ripple_adder.sv
// Ternary ripple-carry adder
// Two carry chains run side by side: one adds a and b, the other adds
// a and the trit-wise negation of b to form a - b. Each stage is a
// full adder made of two half adders whose carries merge with any.
// The carry out of the top trit is dropped, so results wrap.
`timescale 1ns/1ns

module trit_ripple_adder (
    input  ternary_pkg::word_t a,
    input  ternary_pkg::word_t b,
    output ternary_pkg::word_t sum_word,
    output ternary_pkg::word_t diff_word
);

    localparam int N = ternary_pkg::WORD_TRITS;

    // Half adder sum: any of the inputs, corrected twice by the
    // negated consensus so that +1 + +1 gives -1 and -1 + -1 gives +1
    function automatic ternary_pkg::trit_t half_sum(
        input ternary_pkg::trit_t x,
        input ternary_pkg::trit_t y
    );
        ternary_pkg::trit_t partial;
        ternary_pkg::trit_t fix;
        partial = ternary_pkg::trit_any(x, y);
        fix     = ternary_pkg::trit_neg(ternary_pkg::trit_consensus(x, y));
        return ternary_pkg::trit_any(fix, ternary_pkg::trit_any(fix, partial));
    endfunction

    ternary_pkg::word_t neg_b;
    ternary_pkg::word_t addend [2];
    ternary_pkg::word_t total [2];
    ternary_pkg::trit_t carry [2][N];

    for (genvar i = 0; i < N; i++) begin : g_neg
        assign neg_b[2*i +: 2] = ternary_pkg::trit_neg(b[2*i +: 2]);
    end

    // Chain 0 adds b, chain 1 adds -b
    assign addend[0] = b;
    assign addend[1] = neg_b;

    for (genvar c = 0; c < 2; c++) begin : g_chain
        assign carry[c][0] = ternary_pkg::TRIT_ZERO;

        for (genvar i = 0; i < N; i++) begin : g_stage
            ternary_pkg::trit_t sum1;

            // First half adder takes the addend trit and the carry in
            assign sum1 = half_sum(addend[c][2*i +: 2], carry[c][i]);
            assign total[c][2*i +: 2] = half_sum(a[2*i +: 2], sum1);

            if (i < N - 1) begin : g_carry
                ternary_pkg::trit_t carry1;
                ternary_pkg::trit_t carry2;

                assign carry1 = ternary_pkg::trit_consensus(addend[c][2*i +: 2],
                                                            carry[c][i]);
                assign carry2 = ternary_pkg::trit_consensus(a[2*i +: 2], sum1);
                assign carry[c][i+1] = ternary_pkg::trit_any(carry1, carry2);
            end
        end
    end

    assign sum_word  = total[0];
    assign diff_word = total[1];

endmodule

// File: source/trit_logic_unit.sv
// Trit-wise logic unit
// Applies NOT, AND (minimum), OR (maximum) and XOR (wrapped sum)
// to every trit position of a word in parallel. NOT reads a only.
// Purely combinational.
`timescale 1ns/1ns

module trit_logic_unit (
    input  ternary_pkg::word_t a,
    input  ternary_pkg::word_t b,
    output ternary_pkg::word_t not_word,
    output ternary_pkg::word_t and_word,
    output ternary_pkg::word_t or_word,
    output ternary_pkg::word_t xor_word
);

    // One slice of gates per trit, trit 0 in the lowest two bits
    for (genvar i = 0; i < ternary_pkg::WORD_TRITS; i++) begin : g_trit
        ternary_pkg::trit_t a_trit;
        ternary_pkg::trit_t b_trit;

        assign a_trit = a[2*i +: 2];
        assign b_trit = b[2*i +: 2];

        assign not_word[2*i +: 2] = ternary_pkg::trit_neg(a_trit);
        assign and_word[2*i +: 2] = ternary_pkg::trit_min(a_trit, b_trit);
        assign or_word[2*i +: 2]  = ternary_pkg::trit_max(a_trit, b_trit);
        assign xor_word[2*i +: 2] = ternary_pkg::trit_xor(a_trit, b_trit);
    end

endmodule

// File: source/ternary_pkg.sv
// Balanced-ternary ALU shared definitions
// Two-bit trit encoding, word and operation types, request and
// response structs, and the one-trit truth-table functions used by
// the datapath units and the reference model.
// Trit codes are 2'b11 = -1, 2'b00 = 0 and 2'b01 = +1.
// The spare code 2'b10 is read as 0 everywhere.
package ternary_pkg;

    parameter int WORD_TRITS = 9;

    typedef logic [1:0] trit_t;
    typedef logic [2*WORD_TRITS-1:0] word_t;

    localparam trit_t TRIT_NEG  = 2'b11;
    localparam trit_t TRIT_ZERO = 2'b00;
    localparam trit_t TRIT_POS  = 2'b01;

    // Code 3'd7 is left out on purpose and passes operand a through
    typedef enum logic [2:0] {
        OP_NOT  = 3'd0,
        OP_AND  = 3'd1,
        OP_OR   = 3'd2,
        OP_XOR  = 3'd3,
        OP_ADD  = 3'd4,
        OP_SUB  = 3'd5,
        OP_COMP = 3'd6
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        word_t   a;
        word_t   b;
    } alu_req_t;

    typedef struct packed {
        alu_op_e op;
        word_t   result;
    } alu_resp_t;

    // Fold the spare code onto zero
    function automatic trit_t trit_norm(input trit_t t);
        return (t == 2'b10) ? TRIT_ZERO : t;
    endfunction

    function automatic trit_t trit_neg(input trit_t t);
        case (trit_norm(t))
            TRIT_NEG: return TRIT_POS;
            TRIT_POS: return TRIT_NEG;
            default:  return TRIT_ZERO;
        endcase
    endfunction

    // AND is the minimum of the two trits
    function automatic trit_t trit_min(input trit_t x, input trit_t y);
        trit_t p;
        trit_t q;
        p = trit_norm(x);
        q = trit_norm(y);
        if (p == TRIT_NEG || q == TRIT_NEG) return TRIT_NEG;
        if (p == TRIT_ZERO || q == TRIT_ZERO) return TRIT_ZERO;
        return TRIT_POS;
    endfunction

    // OR is the maximum of the two trits
    function automatic trit_t trit_max(input trit_t x, input trit_t y);
        trit_t p;
        trit_t q;
        p = trit_norm(x);
        q = trit_norm(y);
        if (p == TRIT_POS || q == TRIT_POS) return TRIT_POS;
        if (p == TRIT_ZERO || q == TRIT_ZERO) return TRIT_ZERO;
        return TRIT_NEG;
    endfunction

    // Sum of the trits wrapped back into -1..+1
    function automatic trit_t trit_xor(input trit_t x, input trit_t y);
        case ({trit_norm(x), trit_norm(y)})
            {TRIT_NEG, TRIT_NEG}:   return TRIT_POS;
            {TRIT_NEG, TRIT_ZERO}:  return TRIT_NEG;
            {TRIT_ZERO, TRIT_NEG}:  return TRIT_NEG;
            {TRIT_ZERO, TRIT_POS}:  return TRIT_POS;
            {TRIT_POS, TRIT_ZERO}:  return TRIT_POS;
            {TRIT_POS, TRIT_POS}:   return TRIT_NEG;
            default:                return TRIT_ZERO;
        endcase
    endfunction

    // Sum that saturates instead of wrapping
    function automatic trit_t trit_any(input trit_t x, input trit_t y);
        trit_t p;
        trit_t q;
        p = trit_norm(x);
        q = trit_norm(y);
        if (p == q || q == TRIT_ZERO) return p;
        if (p == TRIT_ZERO) return q;
        return TRIT_ZERO;
    endfunction

    // Nonzero only when both trits agree
    function automatic trit_t trit_consensus(input trit_t x, input trit_t y);
        trit_t p;
        p = trit_norm(x);
        return (p == trit_norm(y)) ? p : TRIT_ZERO;
    endfunction

endpackage
